// File: run.sh
#!/usr/bin/env bash
# Compile and run the cnn_quad testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_cnn_quad -o sim_tb \
    || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1

// File: tb.f
verilog/quad_pkg.sv
verilog/quad_ctrl.sv
verilog/pixel_window.sv
verilog/weight_store.sv
verilog/conv_engine.sv
verilog/cnn_quad.sv
tb/cnn_quad_sva.sv
tb/tb_cnn_quad.sv

// File: tb/cnn_quad_sva.sv
`timescale 1ns/1ps

module cnn_quad_sva (
    input logic                              clk_core,
    input logic                              rst,
    input logic                              job_req,
    input logic                              job_ack,
    input logic                              pixel_ready,
    input logic                              result_valid,
    input logic                              result_ready,
    input logic [quad_pkg::result_width-1:0] result_data
);

    ////////////////////////////////////////////////////////////
    // Job handshake
    ////////////////////////////////////////////////////////////
    // Ack may only drop once req is gone
    ack_hold: assert property (@(posedge clk_core) disable iff (rst)
        job_ack && job_req |=> job_ack)
        else $error("job_ack fell while job_req was high");

    ack_no_pixels: assert property (@(posedge clk_core) disable iff (rst)
        job_ack |-> !pixel_ready)
        else $error("pixel_ready high while job_ack was high");

    // Stalled result word must not change
    result_hold: assert property (@(posedge clk_core) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result_data))
        else $error("result changed while stalled");

endmodule

bind cnn_quad cnn_quad_sva u_cnn_quad_sva (
    .clk_core     (clk_core),
    .rst          (rst),
    .job_req      (job_req),
    .job_ack      (job_ack),
    .pixel_ready  (pixel_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_data  (result_data)
);

// File: tb/tb_cnn_quad.sv
`timescale 1ns/1ps

module tb_cnn_quad;

    logic                              clk_core = 1'b0;
    logic                              rst;
    logic                              cfg_wr;
    logic                              cfg_sel;
    quad_pkg::cfg_word_u               cfg_data;
    logic                              job_req;
    logic                              pixel_valid;
    logic [quad_pkg::pixel_width-1:0]  pixel_data;
    logic                              result_ready;
    logic                              job_ack;
    logic                              pixel_ready;
    logic                              result_valid;
    logic [quad_pkg::result_width-1:0] result_data;

    int    seed;
    int    err_cnt;
    int    proto_cnt;
    int    res_cnt;
    bit    bp_mode;
    string test_name;
    int    job_cols [4] = '{16, 16, 3, 8};

    // Current job's stimulus for the reference model
    logic [quad_pkg::pixel_width-1:0]         pix [64];
    logic signed [quad_pkg::weight_width-1:0] wt [quad_pkg::num_ce][quad_pkg::num_taps];
    logic [quad_pkg::result_width-1:0]        exp_q [$];

    cnn_quad u_cnn_quad (
        .clk_core     (clk_core),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_sel      (cfg_sel),
        .cfg_data     (cfg_data),
        .job_req      (job_req),
        .pixel_valid  (pixel_valid),
        .pixel_data   (pixel_data),
        .result_ready (result_ready),
        .job_ack      (job_ack),
        .pixel_ready  (pixel_ready),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    always #20 clk_core = ~clk_core;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    // Window n of engine c is w0*p[n] + w1*p[n+1] + w2*p[n+2]
    function automatic logic [quad_pkg::result_width-1:0] ref_word(int n);
        logic [quad_pkg::result_width-1:0] word;
        int acc;
        word = '0;
        for (int c = 0; c < quad_pkg::num_ce; c++) begin
            acc = 0;
            for (int t = 0; t < quad_pkg::num_taps; t++) begin
                acc += int'(wt[c][t]) * int'(pix[n+t]);
            end
            word[c*quad_pkg::acc_width +: quad_pkg::acc_width] = acc[quad_pkg::acc_width-1:0];
        end
        return word;
    endfunction

    // One clock and new inputs 1 ns after the edge
    task automatic step();
        @(posedge clk_core);
        #1;
        if (bp_mode) begin
            result_ready = 1'($random(seed));
        end
    endtask

    task automatic write_cfg(logic sel, logic [31:0] word);
        cfg_wr   = 1'b1;
        cfg_sel  = sel;
        cfg_data = word;
        step();
        cfg_wr   = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // One complete job with the four-phase handshake
    ////////////////////////////////////////////////////////////
    task automatic run_job(string name, int cols, bit bp, bit extreme);
        int idx;
        int start_cnt;
        bit took;
        test_name = name;
        bp_mode   = bp;
        for (int c = 0; c < quad_pkg::num_ce; c++) begin
            for (int t = 0; t < quad_pkg::num_taps; t++) begin
                if (extreme) begin
                    // Engine 0 all -128, engine 1 all 127, the others alternate
                    wt[c][t] = ((c == 0) || (c > 1 && (c + t) % 2 == 0)) ? 8'h80 : 8'h7f;
                end else begin
                    wt[c][t] = 8'($random(seed));
                end
            end
        end
        for (int n = 0; n < cols; n++) begin
            pix[n] = extreme ? 8'hff : 8'($random(seed));
        end
        write_cfg(1'b0, 32'(cols));
        for (int t = 0; t < quad_pkg::num_taps; t++) begin
            write_cfg(1'b1, {wt[3][t], wt[2][t], wt[1][t], wt[0][t]});
        end
        for (int n = 0; n + 2 < cols; n++) begin
            exp_q.push_back(ref_word(n));
        end
        start_cnt = res_cnt;
        job_req   = 1'b1;
        idx       = 0;
        while (idx < cols) begin
            pixel_valid = bp ? (($random(seed) & 3) != 0) : 1'b1;
            pixel_data  = pix[idx];
            // Inputs and pixel_ready are settled mid cycle
            @(negedge clk_core);
            took = pixel_valid && pixel_ready;
            step();
            if (took) begin
                idx++;
            end
        end
        pixel_valid = 1'b0;
        while (!job_ack) begin
            step();
        end
        assert (exp_q.size() == 0) else begin
            $display("job_ack rose in %s with %0d results still missing", name, exp_q.size());
            proto_cnt++;
        end
        assert (res_cnt - start_cnt == cols - 2) else begin
            $display("Error: %s result count expected %0d got %0d",
                     name, cols - 2, res_cnt - start_cnt);
            err_cnt++;
        end
        repeat (3) step();
        assert (job_ack && !pixel_ready) else begin
            $display("job_ack dropped or pixel_ready rose in %s before job_req fell", name);
            proto_cnt++;
        end
        job_req = 1'b0;
        step();
        assert (!job_ack && !pixel_ready) else begin
            $display("job_ack or pixel_ready still high in %s after job_req fell", name);
            proto_cnt++;
        end
        bp_mode      = 1'b0;
        result_ready = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Comparator
    ////////////////////////////////////////////////////////////
    // Sampled mid cycle for the transfer on the next edge
    always @(negedge clk_core) begin
        logic [quad_pkg::result_width-1:0] exp_word;
        if (!rst && result_valid && result_ready) begin
            res_cnt++;
            assert (exp_q.size() != 0) else begin
                $display("Result word arrived in %s with no result expected", test_name);
                proto_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (result_data == exp_word) else begin
                    $display("Error: %s expected %h got %h", test_name, exp_word, result_data);
                    err_cnt++;
                end
            end
        end
    end

    // Watchdog budget from the job lengths plus margin
    initial begin
        int budget;
        budget = 2000;
        foreach (job_cols[j]) begin
            budget += (job_cols[j] + 10) * 4 * 40;
        end
        #(budget);
        $display("Watchdog timeout, jobs did not finish within %0d ns", budget);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h9f9b3aeb;
        err_cnt      = 0;
        proto_cnt    = 0;
        res_cnt      = 0;
        bp_mode      = 1'b0;
        test_name    = "reset";
        rst          = 1'b1;
        cfg_wr       = 1'b0;
        cfg_sel      = 1'b0;
        cfg_data     = '0;
        job_req      = 1'b0;
        pixel_valid  = 1'b0;
        pixel_data   = '0;
        result_ready = 1'b1;
        repeat (4) @(posedge clk_core);
        #1;
        rst = 1'b0;
        assert (!job_ack && !pixel_ready && !result_valid) else begin
            $display("Outputs not idle after reset");
            proto_cnt++;
        end
        run_job("basic", job_cols[0], 1'b0, 1'b0);
        run_job("backpressure", job_cols[1], 1'b1, 1'b0);
        run_job("reconfig", job_cols[2], 1'b0, 1'b0);
        run_job("extreme", job_cols[3], 1'b0, 1'b1);
        repeat (4) step();
        $display("Summary: %0d value errors, %0d protocol errors, %0d results checked",
                 err_cnt, proto_cnt, res_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/cnn_quad.sv
`timescale 1ns/1ps

module cnn_quad (
    input  logic                              clk_core,
    input  logic                              rst,
    input  logic                              cfg_wr,
    input  logic                              cfg_sel,
    input  quad_pkg::cfg_word_u               cfg_data,
    input  logic                              job_req,
    input  logic                              pixel_valid,
    input  logic [quad_pkg::pixel_width-1:0]  pixel_data,
    input  logic                              result_ready,
    output logic                              job_ack,
    output logic                              pixel_ready,
    output logic                              result_valid,
    output logic [quad_pkg::result_width-1:0] result_data
);

    logic win_clear;
    logic pixel_take;
    logic advance;
    logic result_taken;
    logic win_valid;
    logic [quad_pkg::num_taps-1:0][quad_pkg::pixel_width-1:0] win_pixels;
    logic [quad_pkg::num_ce-1:0][quad_pkg::num_taps-1:0][quad_pkg::weight_width-1:0] taps;

    ////////////////////////////////////////////////////////////
    // Job sequencing
    ////////////////////////////////////////////////////////////
    quad_ctrl u_quad_ctrl (
        .clk_core     (clk_core),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_sel      (cfg_sel),
        .cfg_data     (cfg_data),
        .job_req      (job_req),
        .pixel_valid  (pixel_valid),
        .advance      (advance),
        .result_taken (result_taken),
        .job_ack      (job_ack),
        .pixel_ready  (pixel_ready),
        .pixel_take   (pixel_take),
        .win_clear    (win_clear)
    );

    ////////////////////////////////////////////////////////////
    // Window and weights side by side
    ////////////////////////////////////////////////////////////
    pixel_window u_pixel_window (
        .clk_core   (clk_core),
        .rst        (rst),
        .win_clear  (win_clear),
        .pixel_take (pixel_take),
        .advance    (advance),
        .pixel_data (pixel_data),
        .win_pixels (win_pixels),
        .win_valid  (win_valid)
    );

    weight_store u_weight_store (
        .clk_core (clk_core),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data),
        .taps     (taps)
    );

    // Four MAC lanes and the result register
    conv_engine u_conv_engine (
        .clk_core     (clk_core),
        .rst          (rst),
        .win_pixels   (win_pixels),
        .win_valid    (win_valid),
        .taps         (taps),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_data  (result_data),
        .advance      (advance),
        .result_taken (result_taken)
    );

endmodule

// File: verilog/conv_engine.sv
`timescale 1ns/1ps

module conv_engine (
    input  logic                                                clk_core,
    input  logic                                                rst,
    input  logic [quad_pkg::num_taps-1:0][quad_pkg::pixel_width-1:0] win_pixels,
    input  logic                                                win_valid,
    input  logic [quad_pkg::num_ce-1:0][quad_pkg::num_taps-1:0][quad_pkg::weight_width-1:0] taps,
    input  logic                                                result_ready,
    output logic                                                result_valid,
    output logic [quad_pkg::result_width-1:0]                   result_data,
    output logic                                                advance,
    output logic                                                result_taken
);

    logic                                                       prod_valid;
    logic [quad_pkg::num_ce-1:0][quad_pkg::num_taps-1:0][quad_pkg::prod_width-1:0] prod;
    logic [quad_pkg::num_ce-1:0][quad_pkg::acc_width-1:0]       sum_next;

    // Whole pipeline stalls while the output word waits
    assign advance      = !result_valid || result_ready;
    assign result_taken = result_valid && result_ready;

    ////////////////////////////////////////////////////////////
    // Stage valid bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            prod_valid   <= win_valid;
            result_valid <= prod_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Product stage
    ////////////////////////////////////////////////////////////
    // Pixel is zero extended so the multiply stays signed
    always_ff @(posedge clk_core) begin
        if (advance && win_valid) begin
            for (int c = 0; c < quad_pkg::num_ce; c++) begin
                for (int t = 0; t < quad_pkg::num_taps; t++) begin
                    prod[c][t] <= $signed({1'b0, win_pixels[t]}) * $signed(taps[c][t]);
                end
            end
        end
    end

    // Sign extend each product before the add
    always_comb begin
        for (int c = 0; c < quad_pkg::num_ce; c++) begin
            sum_next[c] = '0;
            for (int t = 0; t < quad_pkg::num_taps; t++) begin
                sum_next[c] = sum_next[c] + quad_pkg::acc_width'($signed(prod[c][t]));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////
    // Engine 0 in the low bits
    always_ff @(posedge clk_core) begin
        if (advance && prod_valid) begin
            for (int c = 0; c < quad_pkg::num_ce; c++) begin
                result_data[c*quad_pkg::acc_width +: quad_pkg::acc_width] <= sum_next[c];
            end
        end
    end

endmodule

// File: verilog/pixel_window.sv
`timescale 1ns/1ps

module pixel_window (
    input  logic                                                clk_core,
    input  logic                                                rst,
    input  logic                                                win_clear,
    input  logic                                                pixel_take,
    input  logic                                                advance,
    input  logic [quad_pkg::pixel_width-1:0]                    pixel_data,
    output logic [quad_pkg::num_taps-1:0][quad_pkg::pixel_width-1:0] win_pixels,
    output logic                                                win_valid
);

    // Fill level saturates at num_taps
    logic [1:0] fill;

    ////////////////////////////////////////////////////////////
    // Fill level and window valid
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || win_clear) begin
            fill      <= '0;
            win_valid <= 1'b0;
        end else if (pixel_take) begin
            if (fill != 2'(quad_pkg::num_taps)) begin
                fill <= fill + 1'b1;
            end
            // New window once this pixel completes it
            win_valid <= (fill >= 2'(quad_pkg::num_taps - 1));
        end else if (advance) begin
            // Product stage took the window
            win_valid <= 1'b0;
        end
    end

    // Oldest pixel in entry 0, newest shifts in at the top
    always_ff @(posedge clk_core) begin
        if (pixel_take) begin
            for (int t = 0; t < quad_pkg::num_taps - 1; t++) begin
                win_pixels[t] <= win_pixels[t+1];
            end
            win_pixels[quad_pkg::num_taps-1] <= pixel_data;
        end
    end

endmodule

// File: verilog/quad_ctrl.sv
`timescale 1ns/1ps

module quad_ctrl (
    input  logic                 clk_core,
    input  logic                 rst,
    input  logic                 cfg_wr,
    input  logic                 cfg_sel,
    input  quad_pkg::cfg_word_u  cfg_data,
    input  logic                 job_req,
    input  logic                 pixel_valid,
    input  logic                 advance,
    input  logic                 result_taken,
    output logic                 job_ack,
    output logic                 pixel_ready,
    output logic                 pixel_take,
    output logic                 win_clear
);

    logic [1:0]                      state;
    logic [quad_pkg::cols_width-1:0] num_cols;
    logic [quad_pkg::cols_width-1:0] pix_cnt;
    logic [quad_pkg::cols_width-1:0] res_cnt;
    logic [quad_pkg::cols_width-1:0] res_target;
    logic                            pix_left;

    // Short jobs give no full window and so no results
    assign res_target = (num_cols > quad_pkg::win_lead) ?
                        num_cols - quad_pkg::win_lead : '0;

    assign pix_left = (pix_cnt != num_cols);

    ////////////////////////////////////////////////////////////
    // Handshake outputs
    ////////////////////////////////////////////////////////////
    assign pixel_ready = (state == quad_pkg::st_run) && pix_left && advance;
    assign pixel_take  = pixel_ready && pixel_valid;
    assign win_clear   = (state == quad_pkg::st_idle) && job_req;
    assign job_ack     = (state == quad_pkg::st_done);

    ////////////////////////////////////////////////////////////
    // Job FSM and counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            state    <= quad_pkg::st_idle;
            num_cols <= '0;
            pix_cnt  <= '0;
            res_cnt  <= '0;
        end else begin
            case (state)
                quad_pkg::st_idle: begin
                    // Job word only taken between jobs
                    if (cfg_wr && !cfg_sel) begin
                        num_cols <= cfg_data.job_cfg.num_cols;
                    end
                    if (job_req) begin
                        pix_cnt <= '0;
                        res_cnt <= '0;
                        state   <= quad_pkg::st_run;
                    end
                end
                quad_pkg::st_run: begin
                    if (pixel_take) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                    if (result_taken) begin
                        res_cnt <= res_cnt + 1'b1;
                    end
                    // All pixels in and the last result accepted
                    if (!pix_left && (res_cnt == res_target)) begin
                        state <= quad_pkg::st_done;
                    end
                end
                quad_pkg::st_done: begin
                    if (!job_req) begin
                        state <= quad_pkg::st_idle;
                    end
                end
                default: begin
                    state <= quad_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/quad_pkg.sv
package quad_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths and counts
    ////////////////////////////////////////////////////////////
    localparam int pixel_width  = 8;
    localparam int weight_width = 8;
    localparam int num_ce       = 4;
    localparam int num_taps     = 3;
    localparam int acc_width    = 19;
    localparam int cols_width   = 8;
    localparam int cfg_width    = 32;
    localparam int result_width = num_ce * acc_width;

    // Unsigned pixel times signed weight needs one extra bit
    localparam int prod_width = pixel_width + weight_width + 1;

    // Pixels needed before the first full window
    localparam logic [cols_width-1:0] win_lead = cols_width'(num_taps - 1);

    // Job controller states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run  = 2'd1;
    localparam logic [1:0] st_done = 2'd2;

    ////////////////////////////////////////////////////////////
    // Configuration word, job or weight view
    ////////////////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [cfg_width-cols_width-1:0] reserved;
            logic [cols_width-1:0]           num_cols;
        } job_cfg;
        // Engine 0 in the low byte
        struct packed {
            logic [num_ce-1:0][weight_width-1:0] weight;
        } weight_cfg;
    } cfg_word_u;

endpackage

// File: verilog/weight_store.sv
`timescale 1ns/1ps

module weight_store (
    input  logic                clk_core,
    input  logic                rst,
    input  logic                cfg_wr,
    input  logic                cfg_sel,
    input  quad_pkg::cfg_word_u cfg_data,
    output logic [quad_pkg::num_ce-1:0][quad_pkg::num_taps-1:0][quad_pkg::weight_width-1:0] taps
);

    logic [1:0] tap_sel;
    logic       wht_wr;

    assign wht_wr = cfg_wr && cfg_sel;

    ////////////////////////////////////////////////////////////
    // Tap row pointer, wraps after the last tap
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            tap_sel <= '0;
        end else if (wht_wr) begin
            if (tap_sel == 2'(quad_pkg::num_taps - 1)) begin
                tap_sel <= '0;
            end else begin
                tap_sel <= tap_sel + 1'b1;
            end
        end
    end

    // One weight word fills the same tap in every engine
    always_ff @(posedge clk_core) begin
        if (wht_wr) begin
            for (int c = 0; c < quad_pkg::num_ce; c++) begin
                taps[c][tap_sel] <= cfg_data.weight_cfg.weight[c];
            end
        end
    end

endmodule
